// ==== list.f ====
verilog/rename_pkg.sv
verilog/arch_reg_file.sv
verilog/rename_reg_file.sv
verilog/rrf_allocator.sv
verilog/src_operand_stage.sv
verilog/rs_request_gen.sv
verilog/rename_unit.sv
dv/rename_checker.sv
dv/tb_rename_unit.sv

// ==== Makefile ====
# Verilator build and run for the rename unit testbench.

VERILATOR ?= verilator
TOP       ?= tb_rename_unit
FILELIST  ?= list.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary -j 0
LINTFLAGS ?= --lint-only -Wall --timing

PASS_MSG := all tests passed
FAIL_MSG := tests failed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG) || ! grep -q "$(PASS_MSG)" $(LOG); then \
		echo "Simulation failed, see $(LOG)"; exit 1; \
	fi

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== dv/tb_rename_unit.sv ====
`timescale 1ns/1ns

module tb_rename_unit;
    import rename_pkg::*;

    localparam int NUM_RRF = NUM_RRF_DEFAULT;
    localparam int DATA_W = DATA_W_DEFAULT;
    localparam int TAG_W = $clog2(NUM_RRF);
    localparam int CNT_W = $clog2(NUM_RRF) + 1;
    localparam int RESET_CYCLES = 2;
    localparam int RANDOM_CYCLES = 2000;
    localparam int DRAIN_CYCLES = 4;
    localparam int TIMEOUT_CYCLES = RANDOM_CYCLES + RANDOM_CYCLES / 4; // Ample margin.
    localparam logic [31:0] SEED = 32'h284c_6b3f;

    logic                  clk_i;
    logic                  reset_i;
    logic [ARCH_IDX_W-1:0] rs1_i;
    logic [ARCH_IDX_W-1:0] rs2_i;
    logic [ARCH_IDX_W-1:0] dst_num_i;
    logic                  dst_en_i;
    logic                  stall_i;
    rs_class_e             inst1_class_i;
    rs_class_e             inst2_class_i;
    logic                  wb1_we_i;
    logic [TAG_W-1:0]      wb1_tag_i;
    logic [DATA_W-1:0]     wb1_data_i;
    logic                  wb2_we_i;
    logic [TAG_W-1:0]      wb2_tag_i;
    logic [DATA_W-1:0]     wb2_data_i;
    logic [COM_NUM_W-1:0]  com_num_i;
    logic                  com_we_i;
    logic [ARCH_IDX_W-1:0] com_dst_i;
    logic [TAG_W-1:0]      com_tag_i;

    logic [DATA_W-1:0]     src1_o;
    logic                  rdy1_o;
    logic [DATA_W-1:0]     src2_o;
    logic                  rdy2_o;
    logic [TAG_W-1:0]      dst_tag_o;
    logic                  dst_en_o;
    logic                  rrf_allocatable_o;
    logic [CNT_W-1:0]      freenum_o;
    logic [TAG_W-1:0]      rrfptr_o;
    logic                  req1_alu_o;
    logic                  req2_alu_o;
    logic [1:0]            req_alu_num_o;
    logic                  req1_branch_o;
    logic                  req2_branch_o;
    logic [1:0]            req_branch_num_o;
    logic                  req1_mul_o;
    logic                  req2_mul_o;
    logic [1:0]            req_mul_num_o;
    logic                  req1_ldst_o;
    logic                  req2_ldst_o;
    logic [1:0]            req_ldst_num_o;

    int error_count;
    int check_count;
    int cycle_count;
    int seed_ret;

    // Tags in flight, oldest first, and whether each tag has its result.
    logic [TAG_W-1:0]      alloc_tag_q [$];
    logic [ARCH_IDX_W-1:0] alloc_dst_q [$];
    logic                  done [NUM_RRF];
    logic [TAG_W-1:0]      next_tag;

    rename_unit #(
        .NUM_RRF(NUM_RRF),
        .DATA_W (DATA_W)
    ) i_rename_unit (.*);

    rename_checker #(
        .NUM_RRF(NUM_RRF),
        .DATA_W (DATA_W)
    ) i_rename_checker (
        .*,
        .dut_src1_i       (src1_o),
        .dut_rdy1_i       (rdy1_o),
        .dut_src2_i       (src2_o),
        .dut_rdy2_i       (rdy2_o),
        .dut_dst_tag_i    (dst_tag_o),
        .dut_dst_en_i     (dst_en_o),
        .dut_allocatable_i(rrf_allocatable_o),
        .dut_freenum_i    (freenum_o),
        .dut_rrfptr_i     (rrfptr_o),
        .dut_req1_i       ({req1_ldst_o, req1_mul_o, req1_branch_o, req1_alu_o}),
        .dut_req2_i       ({req2_ldst_o, req2_mul_o, req2_branch_o, req2_alu_o}),
        .dut_req_num_i    ({req_ldst_num_o, req_mul_num_o, req_branch_num_o, req_alu_num_o}),
        .error_count_o    (error_count),
        .check_count_o    (check_count)
    );

    initial begin
        clk_i = 1'b0;
        forever #5 clk_i = ~clk_i;
    end

    always @(posedge clk_i) begin
        cycle_count++;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Timeout: the run did not end within %0d cycles.", TIMEOUT_CYCLES);
            $display("tests failed");
            $finish;
        end
    end

    task automatic drive_idle();
        dst_en_i = 1'b0;
        stall_i = 1'b0;
        wb1_we_i = 1'b0;
        wb2_we_i = 1'b0;
        com_we_i = 1'b0;
        com_num_i = '0;
    endtask

    task automatic retire_head();
        void'(alloc_tag_q.pop_front());
        void'(alloc_dst_q.pop_front());
    endtask

    task automatic drive_random();
        logic can_alloc;
        int k;
        can_alloc = (alloc_tag_q.size() < NUM_RRF); // Free count before this cycle's commit.
        drive_idle();

        // Commit in order, and only entries whose result is already written.
        if (alloc_tag_q.size() > 0 && done[alloc_tag_q[0]] && $urandom_range(0, 3) != 0) begin
            com_we_i = 1'b1;
            com_dst_i = alloc_dst_q[0];
            com_tag_i = alloc_tag_q[0];
            com_num_i = 2'd1;
            retire_head();
            if (alloc_tag_q.size() > 0 && done[alloc_tag_q[0]] && $urandom_range(0, 3) == 0) begin
                com_num_i = 2'd2;
                retire_head();
            end
        end

        if (alloc_tag_q.size() > 0) begin
            k = $urandom_range(0, alloc_tag_q.size() - 1);
            if (!done[alloc_tag_q[k]] && $urandom_range(0, 1) == 1) begin
                wb1_we_i = 1'b1;
                wb1_tag_i = alloc_tag_q[k];
                wb1_data_i = DATA_W'($urandom);
            end
            k = $urandom_range(0, alloc_tag_q.size() - 1);
            if (!done[alloc_tag_q[k]] && $urandom_range(0, 1) == 1) begin
                wb2_we_i = 1'b1;
                wb2_tag_i = alloc_tag_q[k];
                wb2_data_i = DATA_W'($urandom);
            end
        end
        if (wb1_we_i) done[wb1_tag_i] = 1'b1;
        if (wb2_we_i) done[wb2_tag_i] = 1'b1;

        dst_en_i = ($urandom_range(0, 3) != 0);
        stall_i = ($urandom_range(0, 4) == 0);
        dst_num_i = ARCH_IDX_W'($urandom_range(0, 7)); // Few registers give many hazards.
        if (dst_en_i && !stall_i && can_alloc) begin
            alloc_tag_q.push_back(next_tag);
            alloc_dst_q.push_back(dst_num_i);
            done[next_tag] = 1'b0;
            next_tag = (next_tag == TAG_W'(NUM_RRF - 1)) ? '0 : next_tag + 1'b1;
        end

        rs1_i = ARCH_IDX_W'($urandom_range(0, 7));
        rs2_i = ARCH_IDX_W'($urandom_range(0, 7));
        inst1_class_i = rs_class_e'(3'($urandom_range(0, 4)));
        inst2_class_i = rs_class_e'(3'($urandom_range(0, 4)));
    endtask

    initial begin
        seed_ret = $urandom(SEED);
        cycle_count = 0;
        next_tag = '0;
        reset_i = 1'b1;
        rs1_i = '0;
        rs2_i = '0;
        dst_num_i = '0;
        inst1_class_i = RS_NONE;
        inst2_class_i = RS_NONE;
        wb1_tag_i = '0;
        wb1_data_i = '0;
        wb2_tag_i = '0;
        wb2_data_i = '0;
        com_dst_i = '0;
        com_tag_i = '0;
        drive_idle();

        repeat (RESET_CYCLES) @(posedge clk_i);
        #1;
        reset_i = 1'b0;
        repeat (RANDOM_CYCLES) begin
            drive_random();
            @(posedge clk_i);
            #1;
        end
        drive_idle();
        repeat (DRAIN_CYCLES) @(posedge clk_i);

        $display("Checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0 && check_count > 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

// ==== dv/rename_checker.sv ====
`timescale 1ns/1ns

module rename_checker #(
    parameter int NUM_RRF = rename_pkg::NUM_RRF_DEFAULT,
    parameter int DATA_W = rename_pkg::DATA_W_DEFAULT,
    localparam int TAG_W = $clog2(NUM_RRF),
    localparam int CNT_W = $clog2(NUM_RRF) + 1
) (
    input  logic                              clk_i,
    input  logic                              reset_i,
    input  logic [rename_pkg::ARCH_IDX_W-1:0] rs1_i,
    input  logic [rename_pkg::ARCH_IDX_W-1:0] rs2_i,
    input  logic [rename_pkg::ARCH_IDX_W-1:0] dst_num_i,
    input  logic                              dst_en_i,
    input  logic                              stall_i,
    input  rename_pkg::rs_class_e             inst1_class_i,
    input  rename_pkg::rs_class_e             inst2_class_i,
    input  logic                              wb1_we_i,
    input  logic [TAG_W-1:0]                  wb1_tag_i,
    input  logic [DATA_W-1:0]                 wb1_data_i,
    input  logic                              wb2_we_i,
    input  logic [TAG_W-1:0]                  wb2_tag_i,
    input  logic [DATA_W-1:0]                 wb2_data_i,
    input  logic [rename_pkg::COM_NUM_W-1:0]  com_num_i,
    input  logic                              com_we_i,
    input  logic [rename_pkg::ARCH_IDX_W-1:0] com_dst_i,
    input  logic [TAG_W-1:0]                  com_tag_i,

    input  logic [DATA_W-1:0]                 dut_src1_i,
    input  logic                              dut_rdy1_i,
    input  logic [DATA_W-1:0]                 dut_src2_i,
    input  logic                              dut_rdy2_i,
    input  logic [TAG_W-1:0]                  dut_dst_tag_i,
    input  logic                              dut_dst_en_i,
    input  logic                              dut_allocatable_i,
    input  logic [CNT_W-1:0]                  dut_freenum_i,
    input  logic [TAG_W-1:0]                  dut_rrfptr_i,
    input  logic [3:0]                        dut_req1_i,
    input  logic [3:0]                        dut_req2_i,
    input  logic [7:0]                        dut_req_num_i,

    output int                                error_count_o,
    output int                                check_count_o
);
    import rename_pkg::*;

    // Model state, updated at each rising edge.
    logic [DATA_W-1:0]        m_arf [NUM_ARCH_REGS];
    logic [TAG_W-1:0]         m_tag [NUM_ARCH_REGS];
    logic [NUM_ARCH_REGS-1:0] m_busy;
    logic [DATA_W-1:0]        m_rrf [NUM_RRF];
    logic [NUM_RRF-1:0]       m_valid;
    logic [TAG_W-1:0]         m_ptr;
    logic [CNT_W-1:0]         m_free;

    // Registered outputs the DUT should show after the edge.
    logic [DATA_W-1:0] exp_src1;
    logic [DATA_W-1:0] exp_src2;
    logic              exp_rdy1;
    logic              exp_rdy2;
    logic              exp_dst_en;
    logic [TAG_W-1:0]  exp_dst_tag;
    logic [3:0]        exp_req1;
    logic [3:0]        exp_req2;
    logic [7:0]        exp_req_num;
    logic              primed = 1'b0;

    int error_count = 0;
    int check_count = 0;

    assign error_count_o = error_count;
    assign check_count_o = check_count;

    task automatic check_value(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("Error %s: expected %0h, actual %0h at %0t", name, expected, actual,
                     $time);
        end
    endtask

    // A free register gives its own value, a busy one its written rename data, else the tag.
    task automatic eval_source(input logic [ARCH_IDX_W-1:0] r, output logic [DATA_W-1:0] d,
                               output logic rdy);
        rdy = 1'b1;
        if (r == '0) begin
            d = '0;
        end else if (!m_busy[r]) begin
            d = m_arf[r];
        end else if (m_valid[m_tag[r]]) begin
            d = m_rrf[m_tag[r]];
        end else begin
            d = DATA_W'(m_tag[r]);
            rdy = 1'b0;
        end
    endtask

    function automatic logic [3:0] decode_class(input rs_class_e c);
        return {c == RS_LDST, c == RS_MUL, c == RS_BRANCH, c == RS_ALU};
    endfunction

    always @(posedge clk_i) begin
        logic              fire;
        logic [DATA_W-1:0] com_data;
        if (reset_i) begin
            m_busy = '0;
            m_valid = '0;
            m_ptr = '0;
            m_free = CNT_W'(NUM_RRF);
            exp_rdy1 = 1'b0;
            exp_rdy2 = 1'b0;
            exp_dst_en = 1'b0;
            exp_req1 = '0;
            exp_req2 = '0;
            primed = 1'b1;
        end else begin
            eval_source(rs1_i, exp_src1, exp_rdy1);
            eval_source(rs2_i, exp_src2, exp_rdy2);
            fire = dst_en_i && !stall_i && (m_free != '0);
            exp_dst_en = fire;
            exp_dst_tag = m_ptr;
            exp_req1 = decode_class(inst1_class_i);
            exp_req2 = decode_class(inst2_class_i);

            com_data = m_rrf[com_tag_i]; // Commit reads the entry before this edge's writes.
            if (wb2_we_i) begin
                m_rrf[wb2_tag_i] = wb2_data_i;
                m_valid[wb2_tag_i] = 1'b1;
            end
            if (wb1_we_i) begin
                m_rrf[wb1_tag_i] = wb1_data_i;
                m_valid[wb1_tag_i] = 1'b1;
            end
            if (fire) m_valid[m_ptr] = 1'b0;
            if (com_we_i) begin
                if (com_dst_i != '0) m_arf[com_dst_i] = com_data;
                if (m_tag[com_dst_i] == com_tag_i) m_busy[com_dst_i] = 1'b0;
            end
            if (fire && dst_num_i != '0) begin
                m_busy[dst_num_i] = 1'b1;
                m_tag[dst_num_i] = m_ptr;
            end
            m_free = m_free + CNT_W'(com_num_i) - CNT_W'(fire);
            if (fire) m_ptr = (m_ptr == TAG_W'(NUM_RRF - 1)) ? '0 : m_ptr + 1'b1;
        end
        for (int c = 0; c < 4; c++) begin
            exp_req_num[2*c +: 2] = {1'b0, exp_req1[c]} + {1'b0, exp_req2[c]};
        end
    end

    // Outputs are stable by the falling edge.
    always @(negedge clk_i) begin
        if (primed) begin
            check_value("alloc_freenum", 64'(m_free), 64'(dut_freenum_i));
            check_value("alloc_rrfptr", 64'(m_ptr), 64'(dut_rrfptr_i));
            check_value("alloc_allocatable", 64'(m_free != '0), 64'(dut_allocatable_i));
            check_value("alloc_dst_en", 64'(exp_dst_en), 64'(dut_dst_en_i));
            if (exp_dst_en) check_value("alloc_dst_tag", 64'(exp_dst_tag), 64'(dut_dst_tag_i));
            check_value("operand_rdy1", 64'(exp_rdy1), 64'(dut_rdy1_i));
            check_value("operand_rdy2", 64'(exp_rdy2), 64'(dut_rdy2_i));
            // Registers that were never committed hold no defined value.
            if (!$isunknown(exp_src1)) begin
                check_value("operand_src1", 64'(exp_src1), 64'(dut_src1_i));
            end
            if (!$isunknown(exp_src2)) begin
                check_value("operand_src2", 64'(exp_src2), 64'(dut_src2_i));
            end
            check_value("request_req1", 64'(exp_req1), 64'(dut_req1_i));
            check_value("request_req2", 64'(exp_req2), 64'(dut_req2_i));
            check_value("request_num", 64'(exp_req_num), 64'(dut_req_num_i));
        end
    end

endmodule

// ==== verilog/rename_unit.sv ====
`timescale 1ns/1ns

module rename_unit #(
    parameter int NUM_RRF = rename_pkg::NUM_RRF_DEFAULT,
    parameter int DATA_W = rename_pkg::DATA_W_DEFAULT,
    localparam int TAG_W = $clog2(NUM_RRF),
    localparam int CNT_W = $clog2(NUM_RRF) + 1
) (
    input  logic                              clk_i,
    input  logic                              reset_i,

    input  logic [rename_pkg::ARCH_IDX_W-1:0] rs1_i,
    input  logic [rename_pkg::ARCH_IDX_W-1:0] rs2_i,
    input  logic [rename_pkg::ARCH_IDX_W-1:0] dst_num_i,
    input  logic                              dst_en_i,
    input  logic                              stall_i,
    input  rename_pkg::rs_class_e             inst1_class_i,
    input  rename_pkg::rs_class_e             inst2_class_i,

    input  logic                              wb1_we_i,
    input  logic [TAG_W-1:0]                  wb1_tag_i,
    input  logic [DATA_W-1:0]                 wb1_data_i,
    input  logic                              wb2_we_i,
    input  logic [TAG_W-1:0]                  wb2_tag_i,
    input  logic [DATA_W-1:0]                 wb2_data_i,

    input  logic [rename_pkg::COM_NUM_W-1:0]  com_num_i,
    input  logic                              com_we_i,
    input  logic [rename_pkg::ARCH_IDX_W-1:0] com_dst_i,
    input  logic [TAG_W-1:0]                  com_tag_i,

    output logic [DATA_W-1:0]                 src1_o,
    output logic                              rdy1_o,
    output logic [DATA_W-1:0]                 src2_o,
    output logic                              rdy2_o,
    output logic [TAG_W-1:0]                  dst_tag_o,
    output logic                              dst_en_o,
    output logic                              rrf_allocatable_o,
    output logic [CNT_W-1:0]                  freenum_o,
    output logic [TAG_W-1:0]                  rrfptr_o,

    output logic                              req1_alu_o,
    output logic                              req2_alu_o,
    output logic [1:0]                        req_alu_num_o,
    output logic                              req1_branch_o,
    output logic                              req2_branch_o,
    output logic [1:0]                        req_branch_num_o,
    output logic                              req1_mul_o,
    output logic                              req2_mul_o,
    output logic [1:0]                        req_mul_num_o,
    output logic                              req1_ldst_o,
    output logic                              req2_ldst_o,
    output logic [1:0]                        req_ldst_num_o
);

    logic              alloc_fire;
    logic [TAG_W-1:0]  alloc_tag;

    logic [DATA_W-1:0] arf_rs1_data;
    logic              arf_rs1_busy;
    logic [TAG_W-1:0]  arf_rs1_tag;
    logic [DATA_W-1:0] arf_rs2_data;
    logic              arf_rs2_busy;
    logic [TAG_W-1:0]  arf_rs2_tag;

    logic [DATA_W-1:0] rrf_rs1_data;
    logic              rrf_rs1_valid;
    logic [DATA_W-1:0] rrf_rs2_data;
    logic              rrf_rs2_valid;
    logic [DATA_W-1:0] com_data;

    rrf_allocator #(
        .NUM_RRF(NUM_RRF)
    ) i_rrf_allocator (
        .clk_i            (clk_i),
        .reset_i          (reset_i),
        .req_i            (dst_en_i),
        .stall_i          (stall_i),
        .com_num_i        (com_num_i),
        .alloc_fire_o     (alloc_fire),
        .alloc_tag_o      (alloc_tag),
        .rrfptr_o         (rrfptr_o),
        .freenum_o        (freenum_o),
        .rrf_allocatable_o(rrf_allocatable_o),
        .dst_tag_o        (dst_tag_o),
        .dst_en_o         (dst_en_o)
    );

    arch_reg_file #(
        .NUM_RRF(NUM_RRF),
        .DATA_W (DATA_W)
    ) i_arch_reg_file (
        .clk_i     (clk_i),
        .reset_i   (reset_i),
        .rs1_i     (rs1_i),
        .rs2_i     (rs2_i),
        .rs1_data_o(arf_rs1_data),
        .rs1_busy_o(arf_rs1_busy),
        .rs1_tag_o (arf_rs1_tag),
        .rs2_data_o(arf_rs2_data),
        .rs2_busy_o(arf_rs2_busy),
        .rs2_tag_o (arf_rs2_tag),
        .set_busy_i(alloc_fire),
        .set_num_i (dst_num_i),
        .set_tag_i (alloc_tag),
        .com_we_i  (com_we_i),
        .com_dst_i (com_dst_i),
        .com_tag_i (com_tag_i),
        .com_data_i(com_data)
    );

    // Source lookups index the rename file with the tags held in the register file.
    rename_reg_file #(
        .NUM_RRF(NUM_RRF),
        .DATA_W (DATA_W)
    ) i_rename_reg_file (
        .clk_i      (clk_i),
        .reset_i    (reset_i),
        .rs1_tag_i  (arf_rs1_tag),
        .rs2_tag_i  (arf_rs2_tag),
        .rs1_data_o (rrf_rs1_data),
        .rs1_valid_o(rrf_rs1_valid),
        .rs2_data_o (rrf_rs2_data),
        .rs2_valid_o(rrf_rs2_valid),
        .alloc_i    (alloc_fire),
        .alloc_tag_i(alloc_tag),
        .wb1_we_i   (wb1_we_i),
        .wb1_tag_i  (wb1_tag_i),
        .wb1_data_i (wb1_data_i),
        .wb2_we_i   (wb2_we_i),
        .wb2_tag_i  (wb2_tag_i),
        .wb2_data_i (wb2_data_i),
        .com_tag_i  (com_tag_i),
        .com_data_o (com_data)
    );

    src_operand_stage #(
        .NUM_RRF(NUM_RRF),
        .DATA_W (DATA_W)
    ) i_src_operand_stage (
        .clk_i           (clk_i),
        .reset_i         (reset_i),
        .src1_arf_busy_i (arf_rs1_busy),
        .src1_arf_data_i (arf_rs1_data),
        .src1_arf_tag_i  (arf_rs1_tag),
        .src1_rrf_valid_i(rrf_rs1_valid),
        .src1_rrf_data_i (rrf_rs1_data),
        .src2_arf_busy_i (arf_rs2_busy),
        .src2_arf_data_i (arf_rs2_data),
        .src2_arf_tag_i  (arf_rs2_tag),
        .src2_rrf_valid_i(rrf_rs2_valid),
        .src2_rrf_data_i (rrf_rs2_data),
        .src1_o          (src1_o),
        .rdy1_o          (rdy1_o),
        .src2_o          (src2_o),
        .rdy2_o          (rdy2_o)
    );

    rs_request_gen i_rs_request_gen (
        .clk_i           (clk_i),
        .reset_i         (reset_i),
        .inst1_class_i   (inst1_class_i),
        .inst2_class_i   (inst2_class_i),
        .req1_alu_o      (req1_alu_o),
        .req2_alu_o      (req2_alu_o),
        .req_alu_num_o   (req_alu_num_o),
        .req1_branch_o   (req1_branch_o),
        .req2_branch_o   (req2_branch_o),
        .req_branch_num_o(req_branch_num_o),
        .req1_mul_o      (req1_mul_o),
        .req2_mul_o      (req2_mul_o),
        .req_mul_num_o   (req_mul_num_o),
        .req1_ldst_o     (req1_ldst_o),
        .req2_ldst_o     (req2_ldst_o),
        .req_ldst_num_o  (req_ldst_num_o)
    );

endmodule

// ==== verilog/rs_request_gen.sv ====
`timescale 1ns/1ns

module rs_request_gen (
    input  logic                  clk_i,
    input  logic                  reset_i,
    input  rename_pkg::rs_class_e inst1_class_i,
    input  rename_pkg::rs_class_e inst2_class_i,

    output logic                  req1_alu_o,
    output logic                  req2_alu_o,
    output logic [1:0]            req_alu_num_o,
    output logic                  req1_branch_o,
    output logic                  req2_branch_o,
    output logic [1:0]            req_branch_num_o,
    output logic                  req1_mul_o,
    output logic                  req2_mul_o,
    output logic [1:0]            req_mul_num_o,
    output logic                  req1_ldst_o,
    output logic                  req2_ldst_o,
    output logic [1:0]            req_ldst_num_o
);
    import rename_pkg::*;

    // Bit i of the request vectors stands for this class.
    localparam rs_class_e CLASS_OF [4] = '{RS_ALU, RS_BRANCH, RS_MUL, RS_LDST};

    logic [3:0] req1_q;
    logic [3:0] req2_q;

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            req1_q <= '0;
            req2_q <= '0;
        end else begin
            for (int i = 0; i < 4; i++) begin
                req1_q[i] <= (inst1_class_i == CLASS_OF[i]);
                req2_q[i] <= (inst2_class_i == CLASS_OF[i]);
            end
        end
    end

    assign req1_alu_o = req1_q[0];
    assign req2_alu_o = req2_q[0];
    assign req_alu_num_o = {1'b0, req1_q[0]} + {1'b0, req2_q[0]};

    assign req1_branch_o = req1_q[1];
    assign req2_branch_o = req2_q[1];
    assign req_branch_num_o = {1'b0, req1_q[1]} + {1'b0, req2_q[1]};

    assign req1_mul_o = req1_q[2];
    assign req2_mul_o = req2_q[2];
    assign req_mul_num_o = {1'b0, req1_q[2]} + {1'b0, req2_q[2]};

    assign req1_ldst_o = req1_q[3];
    assign req2_ldst_o = req2_q[3];
    assign req_ldst_num_o = {1'b0, req1_q[3]} + {1'b0, req2_q[3]};

endmodule

// ==== verilog/src_operand_stage.sv ====
`timescale 1ns/1ns

module src_operand_stage #(
    parameter int NUM_RRF = rename_pkg::NUM_RRF_DEFAULT,
    parameter int DATA_W = rename_pkg::DATA_W_DEFAULT,
    localparam int TAG_W = $clog2(NUM_RRF)
) (
    input  logic              clk_i,
    input  logic              reset_i,

    input  logic              src1_arf_busy_i,
    input  logic [DATA_W-1:0] src1_arf_data_i,
    input  logic [TAG_W-1:0]  src1_arf_tag_i,
    input  logic              src1_rrf_valid_i,
    input  logic [DATA_W-1:0] src1_rrf_data_i,

    input  logic              src2_arf_busy_i,
    input  logic [DATA_W-1:0] src2_arf_data_i,
    input  logic [TAG_W-1:0]  src2_arf_tag_i,
    input  logic              src2_rrf_valid_i,
    input  logic [DATA_W-1:0] src2_rrf_data_i,

    output logic [DATA_W-1:0] src1_o,
    output logic              rdy1_o,
    output logic [DATA_W-1:0] src2_o,
    output logic              rdy2_o
);

    // Result is {ready, operand}; a waiting operand carries its tag instead.
    function automatic logic [DATA_W:0] pick_operand(
        input logic              arf_busy,
        input logic [DATA_W-1:0] arf_data,
        input logic [TAG_W-1:0]  arf_tag,
        input logic              rrf_valid,
        input logic [DATA_W-1:0] rrf_data
    );
        if (!arf_busy) begin
            return {1'b1, arf_data};
        end else if (rrf_valid) begin
            return {1'b1, rrf_data};
        end
        return {1'b0, DATA_W'(arf_tag)};
    endfunction

    logic [DATA_W:0] op1;
    logic [DATA_W:0] op2;

    assign op1 = pick_operand(src1_arf_busy_i, src1_arf_data_i, src1_arf_tag_i,
                              src1_rrf_valid_i, src1_rrf_data_i);
    assign op2 = pick_operand(src2_arf_busy_i, src2_arf_data_i, src2_arf_tag_i,
                              src2_rrf_valid_i, src2_rrf_data_i);

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            rdy1_o <= 1'b0;
            rdy2_o <= 1'b0;
        end else begin
            rdy1_o <= op1[DATA_W];
            rdy2_o <= op2[DATA_W];
        end
    end

    always_ff @(posedge clk_i) begin
        src1_o <= op1[DATA_W-1:0];
        src2_o <= op2[DATA_W-1:0];
    end

endmodule

// ==== verilog/rrf_allocator.sv ====
`timescale 1ns/1ns

module rrf_allocator #(
    parameter int NUM_RRF = rename_pkg::NUM_RRF_DEFAULT,
    localparam int TAG_W = $clog2(NUM_RRF),
    localparam int CNT_W = $clog2(NUM_RRF) + 1
) (
    input  logic                             clk_i,
    input  logic                             reset_i,
    input  logic                             req_i,
    input  logic                             stall_i,
    input  logic [rename_pkg::COM_NUM_W-1:0] com_num_i,

    output logic                             alloc_fire_o,
    output logic [TAG_W-1:0]                 alloc_tag_o,
    output logic [TAG_W-1:0]                 rrfptr_o,
    output logic [CNT_W-1:0]                 freenum_o,
    output logic                             rrf_allocatable_o,
    output logic [TAG_W-1:0]                 dst_tag_o,
    output logic                             dst_en_o
);

    logic [TAG_W-1:0] ptr_q;
    logic [TAG_W-1:0] ptr_next;
    logic [CNT_W-1:0] freenum_q;
    logic [TAG_W-1:0] dst_tag_q;
    logic             dst_en_q;
    logic             allocatable;
    logic             fire;

    assign allocatable = (freenum_q != '0);
    assign fire = req_i && !stall_i && allocatable;

    // Wrap explicitly so sizes that are not a power of two still work.
    assign ptr_next = (ptr_q == TAG_W'(NUM_RRF - 1)) ? '0 : ptr_q + 1'b1;

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            ptr_q <= '0;
            freenum_q <= CNT_W'(NUM_RRF);
            dst_en_q <= 1'b0;
        end else begin
            if (fire) begin
                ptr_q <= ptr_next;
            end
            freenum_q <= freenum_q + CNT_W'(com_num_i) - CNT_W'(fire);
            dst_en_q <= fire;
        end
    end

    always_ff @(posedge clk_i) begin
        dst_tag_q <= ptr_q; // Only meaningful while dst_en_o is high.
    end

    assign alloc_fire_o = fire;
    assign alloc_tag_o = ptr_q;
    assign rrfptr_o = ptr_q;
    assign freenum_o = freenum_q;
    assign rrf_allocatable_o = allocatable;
    assign dst_tag_o = dst_tag_q;
    assign dst_en_o = dst_en_q;

endmodule

// ==== verilog/rename_reg_file.sv ====
`timescale 1ns/1ns

module rename_reg_file #(
    parameter int NUM_RRF = rename_pkg::NUM_RRF_DEFAULT,
    parameter int DATA_W = rename_pkg::DATA_W_DEFAULT,
    localparam int TAG_W = $clog2(NUM_RRF)
) (
    input  logic              clk_i,
    input  logic              reset_i,

    input  logic [TAG_W-1:0]  rs1_tag_i,
    input  logic [TAG_W-1:0]  rs2_tag_i,
    output logic [DATA_W-1:0] rs1_data_o,
    output logic              rs1_valid_o,
    output logic [DATA_W-1:0] rs2_data_o,
    output logic              rs2_valid_o,

    input  logic              alloc_i,
    input  logic [TAG_W-1:0]  alloc_tag_i,

    input  logic              wb1_we_i,
    input  logic [TAG_W-1:0]  wb1_tag_i,
    input  logic [DATA_W-1:0] wb1_data_i,
    input  logic              wb2_we_i,
    input  logic [TAG_W-1:0]  wb2_tag_i,
    input  logic [DATA_W-1:0] wb2_data_i,

    input  logic [TAG_W-1:0]  com_tag_i,
    output logic [DATA_W-1:0] com_data_o
);

    logic [DATA_W-1:0]  data_q [NUM_RRF];
    logic [NUM_RRF-1:0] valid_q;

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            valid_q <= '0;
        end else begin
            if (wb2_we_i) begin
                valid_q[wb2_tag_i] <= 1'b1;
            end
            if (wb1_we_i) begin
                valid_q[wb1_tag_i] <= 1'b1;
            end
            // A fresh allocation always starts out waiting for its result.
            if (alloc_i) begin
                valid_q[alloc_tag_i] <= 1'b0;
            end
        end
    end

    // Port 1 is written last so it wins a tag collision.
    always_ff @(posedge clk_i) begin
        if (wb2_we_i) begin
            data_q[wb2_tag_i] <= wb2_data_i;
        end
        if (wb1_we_i) begin
            data_q[wb1_tag_i] <= wb1_data_i;
        end
    end

    assign rs1_data_o = data_q[rs1_tag_i];
    assign rs1_valid_o = valid_q[rs1_tag_i];
    assign rs2_data_o = data_q[rs2_tag_i];
    assign rs2_valid_o = valid_q[rs2_tag_i];

    assign com_data_o = data_q[com_tag_i];

endmodule

// ==== verilog/arch_reg_file.sv ====
`timescale 1ns/1ns

module arch_reg_file #(
    parameter int NUM_RRF = rename_pkg::NUM_RRF_DEFAULT,
    parameter int DATA_W = rename_pkg::DATA_W_DEFAULT,
    localparam int TAG_W = $clog2(NUM_RRF)
) (
    input  logic                              clk_i,
    input  logic                              reset_i,

    input  logic [rename_pkg::ARCH_IDX_W-1:0] rs1_i,
    input  logic [rename_pkg::ARCH_IDX_W-1:0] rs2_i,
    output logic [DATA_W-1:0]                 rs1_data_o,
    output logic                              rs1_busy_o,
    output logic [TAG_W-1:0]                  rs1_tag_o,
    output logic [DATA_W-1:0]                 rs2_data_o,
    output logic                              rs2_busy_o,
    output logic [TAG_W-1:0]                  rs2_tag_o,

    input  logic                              set_busy_i,
    input  logic [rename_pkg::ARCH_IDX_W-1:0] set_num_i,
    input  logic [TAG_W-1:0]                  set_tag_i,

    input  logic                              com_we_i,
    input  logic [rename_pkg::ARCH_IDX_W-1:0] com_dst_i,
    input  logic [TAG_W-1:0]                  com_tag_i,
    input  logic [DATA_W-1:0]                 com_data_i
);
    import rename_pkg::*;

    logic [DATA_W-1:0]        data_q [NUM_ARCH_REGS];
    logic [TAG_W-1:0]         tag_q [NUM_ARCH_REGS];
    logic [NUM_ARCH_REGS-1:0] busy_q;

    logic set_en;
    logic com_tag_match;

    assign set_en = set_busy_i && (set_num_i != '0); // Register 0 is never renamed.

    // Only the youngest producer may release the register.
    assign com_tag_match = (tag_q[com_dst_i] == com_tag_i);

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            busy_q <= '0;
        end else begin
            if (com_we_i && com_tag_match) begin
                busy_q[com_dst_i] <= 1'b0;
            end
            // A rename in the same cycle overrides the release.
            if (set_en) begin
                busy_q[set_num_i] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (com_we_i && (com_dst_i != '0)) begin
            data_q[com_dst_i] <= com_data_i;
        end
        if (set_en) begin
            tag_q[set_num_i] <= set_tag_i;
        end
    end

    assign rs1_data_o = (rs1_i == '0) ? '0 : data_q[rs1_i];
    assign rs1_busy_o = (rs1_i == '0) ? 1'b0 : busy_q[rs1_i];
    assign rs1_tag_o = tag_q[rs1_i];

    assign rs2_data_o = (rs2_i == '0) ? '0 : data_q[rs2_i];
    assign rs2_busy_o = (rs2_i == '0) ? 1'b0 : busy_q[rs2_i];
    assign rs2_tag_o = tag_q[rs2_i];

endmodule

// ==== verilog/rename_pkg.sv ====
package rename_pkg;

    // Architectural register file of a 32-entry RISC-style ISA.
    localparam int NUM_ARCH_REGS = 32;
    localparam int ARCH_IDX_W = $clog2(NUM_ARCH_REGS);

    localparam int NUM_RRF_DEFAULT = 16; // Tags are 4 bits, the free count 5 bits.
    localparam int DATA_W_DEFAULT = 32;

    // Commit retires at most two entries per cycle.
    localparam int COM_NUM_W = 2;

    // Reservation station that an instruction is dispatched to.
    typedef enum logic [2:0] {
        RS_NONE   = 3'd0,
        RS_ALU    = 3'd1,
        RS_BRANCH = 3'd2,
        RS_MUL    = 3'd3,
        RS_LDST   = 3'd4
    } rs_class_e;

endpackage
